/* design/fft_pkg.sv */
package fft_pkg;

	// ##########################################################################
	// Widths of the Q1.7 butterfly datapath
	// ##########################################################################

	localparam int DATA_W     = 8;                      // Sample width, Q1.7
	localparam int COEF_W     = 9;                      // Wide enough for c+s and c-s
	localparam int PROD_W     = DATA_W + COEF_W;        // Full signed product
	localparam int FRAC_W     = 7;                      // Fraction bits of a sample
	localparam int MUL_CYCLES = COEF_W;                 // One shift-add step per coefficient bit
	localparam int CNT_W      = $clog2(MUL_CYCLES + 1); // Iteration counter width

	// ##########################################################################
	// Bundles carried between the blocks
	// ##########################################################################

	typedef struct packed
	{
		logic signed [DATA_W-1:0] re;
		logic signed [DATA_W-1:0] im;
	} cplx_t;

	// One extra bit so that A +/- W*B cannot overflow
	typedef struct packed
	{
		logic signed [DATA_W:0] re;
		logic signed [DATA_W:0] im;
	} cplx_wide_t;

	typedef struct packed
	{
		logic signed [COEF_W-1:0] c;         // Sign-extended cosine term
		logic signed [COEF_W-1:0] c_plus_s;  // Used by the I product
		logic signed [COEF_W-1:0] c_minus_s; // Used by the R product
	} twiddle_t;

	typedef struct packed
	{
		cplx_t      a;
		cplx_t      b;
		logic [1:0] k; // Twiddle index, W = exp(-j*2*pi*k/8)
	} bfly_in_t;

	typedef struct packed
	{
		cplx_wide_t p; // A + W*B
		cplx_wide_t q; // A - W*B
	} bfly_out_t;

	typedef enum logic [1:0]
	{
		SEL_Z, // c * (x - y)
		SEL_R, // y * (c - s)
		SEL_I  // x * (c + s)
	} op_sel_e;

endpackage

/* design/twiddle_rom.sv */
`timescale 1ns/1ps

module twiddle_rom
(
	input  logic               clk,
	input  logic               i_arst_n,
	input  logic [1:0]         i_k,
	output fft_pkg::twiddle_t  o_tw
);

	fft_pkg::twiddle_t tw_next;

	// Precomputed sums keep the pre-adders out of the datapath
	always_comb
	begin
		case (i_k)
			2'd0:    tw_next = '{c:  9'sd127, c_plus_s:  9'sd127, c_minus_s: 9'sd127};
			2'd1:    tw_next = '{c:  9'sd91,  c_plus_s:  9'sd0,   c_minus_s: 9'sd182};
			2'd2:    tw_next = '{c:  9'sd0,   c_plus_s: -9'sd127, c_minus_s: 9'sd127};
			default: tw_next = '{c: -9'sd91,  c_plus_s: -9'sd182, c_minus_s: 9'sd0};
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_tw <= '0;
		end
		else
		begin
			o_tw <= tw_next; // Follows i_k every cycle
		end
	end

endmodule

/* design/seq_multiplier.sv */
`timescale 1ns/1ps

module seq_multiplier
(
	input  logic                                clk,
	input  logic                                i_arst_n,
	input  logic                                i_start,
	input  logic signed [fft_pkg::DATA_W-1:0]   i_a,
	input  logic signed [fft_pkg::COEF_W-1:0]   i_b,
	output logic                                o_done,
	output logic signed [fft_pkg::PROD_W-1:0]   o_prod
);

	logic [fft_pkg::CNT_W-1:0]         cnt;
	logic                              done;
	logic                              last_step;
	logic signed [fft_pkg::PROD_W-1:0] mcand;  // Multiplicand, shifted left each step
	logic [fft_pkg::COEF_W-1:0]        mplier; // Multiplier, shifted right each step
	logic signed [fft_pkg::PROD_W-1:0] acc;

	// The top multiplier bit carries weight -2^(COEF_W-1)
	assign last_step = (cnt == fft_pkg::CNT_W'(1));

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			cnt  <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (i_start)
				cnt <= fft_pkg::CNT_W'(fft_pkg::MUL_CYCLES);
			else if (cnt != '0)
			begin
				cnt  <= cnt - fft_pkg::CNT_W'(1);
				done <= last_step; // Product is final on this edge
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_start)
		begin
			mcand  <= {{(fft_pkg::PROD_W-fft_pkg::DATA_W){i_a[fft_pkg::DATA_W-1]}}, i_a};
			mplier <= i_b;
			acc    <= '0;
		end
		else if (cnt != '0)
		begin
			if (mplier[0])
				acc <= last_step ? acc - mcand : acc + mcand;
			mcand  <= mcand <<< 1;
			mplier <= mplier >> 1;
		end
	end

	assign o_done = done;
	assign o_prod = acc; // Holds after done until the next start

endmodule

/* design/twiddle_ctrl.sv */
`timescale 1ns/1ps

module twiddle_ctrl
(
	input  logic             clk,
	input  logic             i_arst_n,
	input  logic             i_start,
	input  logic             i_mul_done,
	output logic             o_busy,
	output logic             o_capture,
	output logic             o_mul_start,
	output fft_pkg::op_sel_e o_sel,
	output logic             o_load_z,
	output logic             o_load_re,
	output logic             o_load_im,
	output logic             o_rot_valid
);

	typedef enum logic [2:0]
	{
		IDLE,
		WAIT_TW,
		CALC_Z,
		CALC_R,
		CALC_I,
		DONE
	} state_e;

	state_e state;
	state_e state_next;

	// ##########################################################################
	// State register and transitions
	// ##########################################################################

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:    if (i_start) state_next = WAIT_TW; // Starts while busy are dropped
			WAIT_TW: state_next = CALC_Z;
			CALC_Z:  if (i_mul_done) state_next = CALC_R;
			CALC_R:  if (i_mul_done) state_next = CALC_I;
			CALC_I:  if (i_mul_done) state_next = DONE;
			default: state_next = IDLE;
		endcase
	end

	// ##########################################################################
	// Strobes and operand select
	// ##########################################################################

	assign o_busy    = (state != IDLE);
	assign o_capture = i_start && (state == IDLE);

	// One multiplier start per product, chained directly off the previous done
	assign o_mul_start = (state == WAIT_TW)
	                  || (state == CALC_Z && i_mul_done)
	                  || (state == CALC_R && i_mul_done);

	// Select moves ahead in the done cycle so the restart latches the next operands
	always_comb
	begin
		case (state)
			CALC_Z:  o_sel = i_mul_done ? fft_pkg::SEL_R : fft_pkg::SEL_Z;
			CALC_R:  o_sel = i_mul_done ? fft_pkg::SEL_I : fft_pkg::SEL_R;
			CALC_I:  o_sel = fft_pkg::SEL_I;
			default: o_sel = fft_pkg::SEL_Z;
		endcase
	end

	assign o_load_z    = (state == CALC_Z) && i_mul_done;
	assign o_load_re   = (state == CALC_R) && i_mul_done;
	assign o_load_im   = (state == CALC_I) && i_mul_done;
	assign o_rot_valid = (state == DONE); // One cycle after load_im

endmodule

/* design/twiddle_datapath.sv */
`timescale 1ns/1ps

module twiddle_datapath
(
	input  logic                              clk,
	input  logic                              i_arst_n,
	input  logic                              i_capture,
	input  fft_pkg::cplx_t                    i_b,
	input  fft_pkg::twiddle_t                 i_tw,
	input  fft_pkg::op_sel_e                  i_sel,
	input  logic [fft_pkg::PROD_W-1:0]        i_prod,
	input  logic                              i_load_z,
	input  logic                              i_load_re,
	input  logic                              i_load_im,
	output logic signed [fft_pkg::DATA_W-1:0] o_mul_a,
	output logic signed [fft_pkg::COEF_W-1:0] o_mul_b,
	output fft_pkg::cplx_t                    o_rot
);

	localparam int TOP = fft_pkg::FRAC_W + fft_pkg::DATA_W - 1;

	fft_pkg::cplx_t                    b_q;
	logic                              tw_load;   // ROM output is valid the cycle after capture
	logic signed [fft_pkg::COEF_W-1:0] c_plus_s_q;
	logic signed [fft_pkg::COEF_W-1:0] c_minus_s_q;
	logic signed [fft_pkg::COEF_W-1:0] x_minus_y;
	logic signed [fft_pkg::PROD_W-1:0] z_q;
	logic signed [fft_pkg::PROD_W-1:0] re_sum;
	logic signed [fft_pkg::PROD_W-1:0] im_diff;
	fft_pkg::cplx_t                    rot_q;

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			tw_load <= 1'b0;
		else
			tw_load <= i_capture;
	end

	always_ff @(posedge clk)
	begin
		if (i_capture)
			b_q <= i_b;
		if (tw_load)
		begin
			c_plus_s_q  <= i_tw.c_plus_s;  // The ROM moves on with i_k, so keep the sums
			c_minus_s_q <= i_tw.c_minus_s;
		end
		if (i_load_z)
			z_q <= i_prod;
		if (i_load_re)
			rot_q.re <= re_sum[TOP:fft_pkg::FRAC_W];  // Floor and wrap to 8 bits
		if (i_load_im)
			rot_q.im <= im_diff[TOP:fft_pkg::FRAC_W];
	end

	// x - y can reach 255, hence the extra bit
	assign x_minus_y = {b_q.re[fft_pkg::DATA_W-1], b_q.re} - {b_q.im[fft_pkg::DATA_W-1], b_q.im};

	always_comb
	begin
		case (i_sel)
			fft_pkg::SEL_R: {o_mul_a, o_mul_b} = {b_q.im, c_minus_s_q};
			fft_pkg::SEL_I: {o_mul_a, o_mul_b} = {b_q.re, c_plus_s_q};
			default:        {o_mul_a, o_mul_b} = {i_tw.c[fft_pkg::DATA_W-1:0], x_minus_y};
		endcase
	end

	assign re_sum  = $signed(i_prod) + z_q;  // Re = R + Z
	assign im_diff = $signed(i_prod) - z_q;  // Im = I - Z
	assign o_rot   = rot_q;

endmodule

/* design/butterfly_addsub.sv */
`timescale 1ns/1ps

module butterfly_addsub
(
	input  logic               clk,
	input  logic               i_arst_n,
	input  logic               i_capture,
	input  fft_pkg::cplx_t     i_a,
	input  logic               i_rot_valid,
	input  fft_pkg::cplx_t     i_rot,
	output logic               o_valid,
	output fft_pkg::bfly_out_t o_out
);

	fft_pkg::cplx_t     a_q;
	fft_pkg::bfly_out_t sum_diff;

	// Sign-extend both sides by one bit so no component can overflow
	always_comb
	begin
		sum_diff.p.re = {a_q.re[fft_pkg::DATA_W-1], a_q.re} + {i_rot.re[fft_pkg::DATA_W-1], i_rot.re};
		sum_diff.p.im = {a_q.im[fft_pkg::DATA_W-1], a_q.im} + {i_rot.im[fft_pkg::DATA_W-1], i_rot.im};
		sum_diff.q.re = {a_q.re[fft_pkg::DATA_W-1], a_q.re} - {i_rot.re[fft_pkg::DATA_W-1], i_rot.re};
		sum_diff.q.im = {a_q.im[fft_pkg::DATA_W-1], a_q.im} - {i_rot.im[fft_pkg::DATA_W-1], i_rot.im};
	end

	always_ff @(posedge clk)
	begin
		if (i_capture)
			a_q <= i_a;
		if (i_rot_valid)
			o_out <= sum_diff; // Held until the next result
	end

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_rot_valid;
	end

endmodule

/* design/butterfly_top.sv */
`timescale 1ns/1ps

module butterfly_top
(
	input  logic               clk,
	input  logic               i_arst_n,
	input  logic               i_start,
	input  fft_pkg::bfly_in_t  i_in,
	output logic               o_valid,
	output logic               o_busy,
	output fft_pkg::bfly_out_t o_out
);

	fft_pkg::twiddle_t                 tw;
	fft_pkg::op_sel_e                  sel;
	fft_pkg::cplx_t                    rot;
	logic                              capture;
	logic                              mul_start;
	logic                              mul_done;
	logic                              load_z;
	logic                              load_re;
	logic                              load_im;
	logic                              rot_valid;
	logic signed [fft_pkg::DATA_W-1:0] mul_a;
	logic signed [fft_pkg::COEF_W-1:0] mul_b;
	logic signed [fft_pkg::PROD_W-1:0] prod;

	twiddle_rom u_rom (.clk(clk), .i_arst_n(i_arst_n), .i_k(i_in.k), .o_tw(tw));

	twiddle_ctrl u_ctrl (.clk(clk), .i_arst_n(i_arst_n), .i_start(i_start),
		.i_mul_done(mul_done), .o_busy(o_busy), .o_capture(capture), .o_mul_start(mul_start),
		.o_sel(sel), .o_load_z(load_z), .o_load_re(load_re), .o_load_im(load_im),
		.o_rot_valid(rot_valid));

	seq_multiplier u_mul (.clk(clk), .i_arst_n(i_arst_n), .i_start(mul_start), .i_a(mul_a),
		.i_b(mul_b), .o_done(mul_done), .o_prod(prod));

	twiddle_datapath u_dp (.clk(clk), .i_arst_n(i_arst_n), .i_capture(capture), .i_b(i_in.b),
		.i_tw(tw), .i_sel(sel), .i_prod(prod), .i_load_z(load_z), .i_load_re(load_re),
		.i_load_im(load_im), .o_mul_a(mul_a), .o_mul_b(mul_b), .o_rot(rot));

	butterfly_addsub u_addsub (.clk(clk), .i_arst_n(i_arst_n), .i_capture(capture),
		.i_a(i_in.a), .i_rot_valid(rot_valid), .i_rot(rot), .o_valid(o_valid), .o_out(o_out));

endmodule

/* tb/tb_butterfly.sv */
`timescale 1ns/1ps

module tb_butterfly;

	localparam int NUM_DIRECTED = 3 + 12;
	localparam int NUM_RANDOM   = 200;
	localparam int NUM_TESTS    = NUM_DIRECTED + NUM_RANDOM + 1;  // Last one is the busy test
	localparam int CYCLE_LIMIT  = (NUM_TESTS + 4) * 40;

	logic               clk;
	logic               i_arst_n;
	logic               i_start;
	fft_pkg::bfly_in_t  i_in;
	logic               o_valid;
	logic               o_busy;
	fft_pkg::bfly_out_t o_out;

	fft_pkg::bfly_out_t expected_q[$];  // One entry per accepted start
	fft_pkg::bfly_out_t expected;
	fft_pkg::bfly_out_t held_out;
	bit                 have_result;
	int                 results_seen;
	int                 cycle_count;
	logic [31:0]        rng_state;

	butterfly_top u_dut (.clk(clk), .i_arst_n(i_arst_n), .i_start(i_start), .i_in(i_in),
		.o_valid(o_valid), .o_busy(o_busy), .o_out(o_out));

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ##########################################################################
	// Reference model and stimulus helpers
	// ##########################################################################

	function automatic logic [31:0] xorshift32(input logic [31:0] v);
		logic [31:0] t;
		t = v ^ (v << 13);
		t = t ^ (t >> 17);
		t = t ^ (t << 5);
		return t;
	endfunction

	// W*B = (c*x - s*y) + j(s*x + c*y), floored to Q1.7 and wrapped to 8 bits
	function automatic fft_pkg::bfly_out_t ref_butterfly(input fft_pkg::bfly_in_t op);
		int                 c;
		int                 s;
		logic [31:0]        re_bits;
		logic [31:0]        im_bits;
		fft_pkg::cplx_t     rot;
		fft_pkg::bfly_out_t res;
		case (op.k)
			2'd0:    begin c = 127; s = 0;    end
			2'd1:    begin c = 91;  s = -91;  end
			2'd2:    begin c = 0;   s = -127; end
			default: begin c = -91; s = -91;  end
		endcase
		re_bits = c * int'(op.b.re) - s * int'(op.b.im);
		im_bits = s * int'(op.b.re) + c * int'(op.b.im);
		rot.re = re_bits[fft_pkg::FRAC_W+7:fft_pkg::FRAC_W];
		rot.im = im_bits[fft_pkg::FRAC_W+7:fft_pkg::FRAC_W];
		res.p.re = 9'(int'(op.a.re) + int'(rot.re));
		res.p.im = 9'(int'(op.a.im) + int'(rot.im));
		res.q.re = 9'(int'(op.a.re) - int'(rot.re));
		res.q.im = 9'(int'(op.a.im) - int'(rot.im));
		return res;
	endfunction

	function automatic fft_pkg::bfly_in_t make_op(input int a_re, input int a_im,
		input int b_re, input int b_im, input int k);
		fft_pkg::bfly_in_t op;
		op.a.re = 8'(a_re);
		op.a.im = 8'(a_im);
		op.b.re = 8'(b_re);
		op.b.im = 8'(b_im);
		op.k    = 2'(k);
		return op;
	endfunction

	task automatic random_op(output fft_pkg::bfly_in_t op);
		rng_state = xorshift32(rng_state);
		op.a      = rng_state[15:0];
		op.b      = rng_state[31:16];
		rng_state = xorshift32(rng_state);
		op.k      = rng_state[1:0];
	endtask

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_cplx_wide(input string name, input fft_pkg::cplx_wide_t expected_val,
		input fft_pkg::cplx_wide_t actual);
		if (actual !== expected_val)
		begin
			$display("CHECK FAILED at %0t: %s expected (re %0d, im %0d), got (re %0d, im %0d)",
				$time, name, expected_val.re, expected_val.im, actual.re, actual.im);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected_val, input logic actual);
		if (actual !== expected_val)
		begin
			$display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expected_val,
				actual);
			abort_run();
		end
	endtask

	// Starts one operation and waits for its result, checking o_busy on the way
	task automatic run_op(input fft_pkg::bfly_in_t op, input bit poke_busy);
		int                waited;
		fft_pkg::bfly_in_t junk;
		expected_q.push_back(ref_butterfly(op));
		i_in    = op;
		i_start = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		random_op(junk);
		i_in   = junk;  // Operands are latched on the start edge only
		waited = 0;
		while (!o_valid)
		begin
			check_flag("o_busy", 1'b1, o_busy);
			i_start = poke_busy && (waited == 3);  // A start while busy must be ignored
			@(negedge clk);
			waited++;
		end
	endtask

	// ##########################################################################
	// Monitor and watchdog
	// ##########################################################################

	always @(negedge clk)
	begin
		if (o_valid)
		begin
			if (expected_q.size() == 0)
			begin
				$display("An o_valid pulse arrived at %0t with no operation outstanding", $time);
				abort_run();
			end
			expected = expected_q.pop_front();
			check_cplx_wide("o_out.p", expected.p, o_out.p);
			check_cplx_wide("o_out.q", expected.q, o_out.q);
			check_flag("o_busy", 1'b0, o_busy);
			held_out     = o_out;
			have_result  = 1'b1;
			results_seen = results_seen + 1;
		end
		else if (have_result)
		begin
			check_cplx_wide("o_out.p held", held_out.p, o_out.p);  // Must not move between pulses
			check_cplx_wide("o_out.q held", held_out.q, o_out.q);
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles while waiting for a result", cycle_count);
			abort_run();
		end
	end

	// ##########################################################################
	// Test sequence
	// ##########################################################################

	initial
	begin
		fft_pkg::bfly_in_t op;
		$timeformat(-9, 0, " ns", 0);
		rng_state    = 32'd45;
		have_result  = 1'b0;
		results_seen = 0;
		cycle_count  = 0;
		i_arst_n     = 1'b0;
		i_start      = 1'b0;
		i_in         = '0;
		repeat (2) @(negedge clk);
		check_flag("o_valid", 1'b0, o_valid);
		check_flag("o_busy", 1'b0, o_busy);
		i_arst_n = 1'b1;
		@(negedge clk);
		check_flag("o_valid", 1'b0, o_valid);
		check_flag("o_busy", 1'b0, o_busy);

		// Trivial twiddle with zero, largest and smallest B
		run_op(make_op(50, -30, 0, 0, 0), 1'b0);
		run_op(make_op(-100, 77, 127, 127, 0), 1'b0);
		run_op(make_op(127, -128, -128, -128, 0), 1'b0);

		for (int k = 0; k < 4; k++)
		begin
			run_op(make_op(0, 0, -128, 127, k), 1'b0);  // x - y needs 9 bits
			run_op(make_op(127, -128, 127, -128, k), 1'b0);
			run_op(make_op(-128, 127, -128, -128, k), 1'b0);
		end

		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			random_op(op);
			run_op(op, 1'b0);
		end

		random_op(op);
		run_op(op, 1'b1);
		repeat (40)
		begin
			@(negedge clk);
			check_flag("o_valid", 1'b0, o_valid);
			check_flag("o_busy", 1'b0, o_busy);
		end

		if (results_seen == NUM_TESTS && expected_q.size() == 0)
		begin
			$display("Simulation passed");
			$finish;
		end
		else
		begin
			$display("Saw %0d results, but %0d operations were started", results_seen, NUM_TESTS);
			abort_run();
		end
	end

endmodule

/* files.f */
design/fft_pkg.sv
design/twiddle_rom.sv
design/seq_multiplier.sv
design/twiddle_ctrl.sv
design/twiddle_datapath.sv
design/butterfly_addsub.sv
design/butterfly_top.sv
tb/tb_butterfly.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the butterfly testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_butterfly -f files.f -o sim_butterfly

./obj_dir/sim_butterfly 2>&1 | tee sim.log

if grep -q "Simulation passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
